/* design/zbus_decode.sv */
`timescale 1ns/1ps

module zbus_decode (
    input  logic              fclk,
    input  logic              rst_n,
    input  logic [15:0]       a,
    input  zx_pkg::data_t     din,
    input  logic              iorq_n,
    input  logic              rd_n,
    input  logic              wr_n,
    input  logic              m1_n,
    output zx_pkg::port_cmd_t cmd,
    output logic              intack
);

    // {m1, wr, rd, iorq}, active high
    logic [3:0] strb_s1;
    logic [3:0] strb_s2;

    logic iorq_s;
    logic rd_s;
    logic wr_s;
    logic m1_s;
    logic io_cyc;
    logic iowr;
    logic iord;
    logic ack;

    logic          io_q;
    logic          iowr_q;
    logic          iord_q;
    logic          ack_q;
    logic          wr_edge;
    logic [15:0]   a_q;
    zx_pkg::data_t din_q;

    function automatic zx_pkg::port_e classify(input logic [15:0] addr);
        zx_pkg::port_e p;
        p = zx_pkg::PORT_NONE;
        if (addr == zx_pkg::PORT_7FFD_ADDR) begin
            p = zx_pkg::PORT_7FFD;
        end else if (addr[7:0] == zx_pkg::XT_PORT_LO) begin
            if (addr[15:8] == zx_pkg::HI_BORDER) begin
                p = zx_pkg::PORT_BORDER;
            end else if (addr[15:10] == zx_pkg::HI_XT_PAGE[7:2]) begin
                p = zx_pkg::PORT_XT_PAGE;
            end else if (addr[15:8] == zx_pkg::HI_SYSCONF) begin
                p = zx_pkg::PORT_SYSCONF;
            end else if (addr[15:8] == zx_pkg::HI_MEMCONF) begin
                p = zx_pkg::PORT_MEMCONF;
            end else if (addr[15:8] == zx_pkg::HI_INTMASK) begin
                p = zx_pkg::PORT_INTMASK;
            end
        end else if (addr[0] == zx_pkg::FE_LO[0]) begin
            // ula port, only a0 matters
            p = zx_pkg::PORT_FE;
        end
        return p;
    endfunction

    // two-stage sync of the z80 strobes
    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            strb_s1 <= '0;
            strb_s2 <= '0;
        end else begin
            strb_s1 <= ~{m1_n, wr_n, rd_n, iorq_n};
            strb_s2 <= strb_s1;
        end
    end

    assign iorq_s = strb_s2[0];
    assign rd_s   = strb_s2[1];
    assign wr_s   = strb_s2[2];
    assign m1_s   = strb_s2[3];

    // m1 with iorq is an interrupt acknowledge, never a port access
    assign io_cyc = iorq_s & ~m1_s;
    assign iowr   = io_cyc & wr_s;
    assign iord   = io_cyc & rd_s;
    assign ack    = iorq_s & m1_s;

    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            io_q    <= 1'b0;
            iowr_q  <= 1'b0;
            iord_q  <= 1'b0;
            ack_q   <= 1'b0;
            wr_edge <= 1'b0;
        end else begin
            io_q    <= io_cyc;
            iowr_q  <= iowr;
            iord_q  <= iord;
            ack_q   <= ack;
            wr_edge <= iowr & ~iowr_q;
        end
    end

    // address and data held for the command stage
    always_ff @(posedge fclk) begin
        if (io_cyc) begin
            a_q   <= a;
            din_q <= din;
        end
    end

    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            cmd.wr_stb <= 1'b0;
            cmd.rd     <= 1'b0;
            cmd.port   <= zx_pkg::PORT_NONE;
            cmd.idx    <= 2'd0;
            cmd.data   <= '0;
            intack     <= 1'b0;
        end else begin
            cmd.wr_stb <= wr_edge;
            cmd.rd     <= iord_q;
            cmd.port   <= io_q ? classify(a_q) : zx_pkg::PORT_NONE;
            cmd.idx    <= a_q[9:8];
            intack     <= ack_q;
            if (wr_edge) begin
                cmd.data <= din_q;
            end
        end
    end

endmodule

/* design/zbus_io.sv */
`timescale 1ns/1ps

module zbus_io #(
    parameter int INT_LEN = 32
) (
    input  logic          fclk,
    input  logic          rst_n,
    input  logic [15:0]   a,
    input  zx_pkg::data_t din,
    input  logic          iorq_n,
    input  logic          rd_n,
    input  logic          wr_n,
    input  logic          m1_n,
    input  logic [4:0]    keys,
    input  logic          int_start,
    output zx_pkg::data_t dout,
    output logic          dout_en,
    output logic          int_n,
    output zx_pkg::data_t border,
    output logic          beep,
    output logic [1:0]    turbo,
    output zx_pkg::page_t mem_page,
    output logic          rom_sel
);

    zx_pkg::port_cmd_t port_cmd;
    zx_pkg::data_t     rd_data;
    zx_pkg::data_t     vect;
    logic              intack;
    logic              vect_en;
    logic              frame_int_en;

    zbus_decode zbus_decode_i (
        .fclk   (fclk),
        .rst_n  (rst_n),
        .a      (a),
        .din    (din),
        .iorq_n (iorq_n),
        .rd_n   (rd_n),
        .wr_n   (wr_n),
        .m1_n   (m1_n),
        .cmd    (port_cmd),
        .intack (intack)
    );

    zport_regs zport_regs_i (
        .fclk         (fclk),
        .rst_n        (rst_n),
        .cmd          (port_cmd),
        .win          (a[15:14]),
        .keys         (keys),
        .rd_data      (rd_data),
        .border       (border),
        .beep         (beep),
        .turbo        (turbo),
        .mem_page     (mem_page),
        .rom_sel      (rom_sel),
        .frame_int_en (frame_int_en)
    );

    zint_gen #(
        .INT_LEN (INT_LEN)
    ) zint_gen_i (
        .fclk      (fclk),
        .rst_n     (rst_n),
        .int_start (int_start),
        .int_en    (frame_int_en),
        .intack    (intack),
        .int_n     (int_n),
        .vect      (vect),
        .vect_en   (vect_en)
    );

    // im2 vector wins over port data during acknowledge
    assign dout    = vect_en ? vect : rd_data;
    assign dout_en = port_cmd.rd | vect_en;

endmodule

/* design/zint_gen.sv */
`timescale 1ns/1ps

module zint_gen #(
    parameter int INT_LEN = 32
) (
    input  logic          fclk,
    input  logic          rst_n,
    input  logic          int_start,
    input  logic          int_en,
    input  logic          intack,
    output logic          int_n,
    output zx_pkg::data_t vect,
    output logic          vect_en
);

    localparam int CNT_W = $clog2(INT_LEN + 1);

    typedef enum logic [1:0] {
        INT_IDLE,
        INT_ACTIVE,
        INT_ACKED
    } int_state_e;

    int_state_e state;
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= INT_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                INT_IDLE: begin
                    cnt <= '0;
                    if (int_start && int_en) begin
                        state <= INT_ACTIVE;
                    end
                end
                INT_ACTIVE: begin
                    cnt <= cnt + 1'b1;
                    if (intack) begin
                        state <= INT_ACKED;
                    end else if (cnt == CNT_W'(INT_LEN - 1)) begin
                        // no acknowledge within the pulse
                        state <= INT_IDLE;
                    end
                end
                INT_ACKED: begin
                    // wait for the ack cycle to end
                    if (!intack) begin
                        state <= INT_IDLE;
                    end
                end
                default: begin
                    state <= INT_IDLE;
                end
            endcase
        end
    end

    assign int_n   = (state != INT_ACTIVE);
    assign vect_en = intack && (state != INT_IDLE);
    assign vect    = zx_pkg::IM2_VECT_FRM;

endmodule

/* design/zport_regs.sv */
`timescale 1ns/1ps

module zport_regs (
    input  logic              fclk,
    input  logic              rst_n,
    input  zx_pkg::port_cmd_t cmd,
    input  logic [1:0]        win,
    input  logic [4:0]        keys,
    output zx_pkg::data_t     rd_data,
    output zx_pkg::data_t     border,
    output logic              beep,
    output logic [1:0]        turbo,
    output zx_pkg::page_t     mem_page,
    output logic              rom_sel,
    output logic              frame_int_en
);

    zx_pkg::data_t    sysconf;
    zx_pkg::memconf_t memconf;
    zx_pkg::data_t    intmask;
    zx_pkg::page_t    xt_page [4];

    // border, beeper and configuration registers
    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            border  <= '0;
            beep    <= 1'b0;
            sysconf <= '0;
            memconf <= '0;
            intmask <= zx_pkg::INTMASK_RST;
        end else if (cmd.wr_stb) begin
            case (cmd.port)
                zx_pkg::PORT_FE: begin
                    border <= zx_pkg::BORDER_FE_BASE + {5'd0, cmd.data[2:0]};
                    beep   <= cmd.data[4];
                end
                zx_pkg::PORT_7FFD: begin
                    // 128k rom select
                    memconf.rom_bank[0] <= cmd.data[4];
                end
                zx_pkg::PORT_BORDER: begin
                    border <= cmd.data;
                end
                zx_pkg::PORT_SYSCONF: begin
                    sysconf <= cmd.data;
                end
                zx_pkg::PORT_MEMCONF: begin
                    memconf <= zx_pkg::memconf_t'(cmd.data);
                end
                zx_pkg::PORT_INTMASK: begin
                    intmask <= cmd.data;
                end
                default: begin
                end
            endcase
        end
    end

    // page registers of the four 16k windows
    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                xt_page[i] <= '0;
            end
        end else if (cmd.wr_stb) begin
            if (cmd.port == zx_pkg::PORT_XT_PAGE) begin
                xt_page[cmd.idx] <= cmd.data;
            end else if (cmd.port == zx_pkg::PORT_7FFD) begin
                // 7ffd pages the top window only
                xt_page[3] <= {5'd0, cmd.data[2:0]};
            end
        end
    end

    assign turbo        = sysconf[1:0];
    assign frame_int_en = intmask[zx_pkg::INTMASK_FRM_BIT];

    // window 0 is rom unless mapped to ram
    always_comb begin
        rom_sel = (win == 2'd0) && !memconf.w0_ram;
        if (rom_sel) begin
            mem_page = zx_pkg::page_t'(memconf.rom_bank);
        end else begin
            mem_page = xt_page[win];
        end
    end

    // readback mux
    always_comb begin
        case (cmd.port)
            zx_pkg::PORT_FE: begin
                rd_data = {3'b111, keys};
            end
            zx_pkg::PORT_XT_PAGE: begin
                rd_data = xt_page[cmd.idx];
            end
            zx_pkg::PORT_MEMCONF: begin
                rd_data = memconf;
            end
            default: begin
                rd_data = zx_pkg::RD_DEFAULT;
            end
        endcase
    end

endmodule

/* design/zx_pkg.sv */
package zx_pkg;

    // z80 data byte and page numbers
    typedef logic [7:0] data_t;
    typedef logic [7:0] page_t;

    // decoded i/o ports
    typedef enum logic [2:0] {
        PORT_NONE,
        PORT_FE,
        PORT_7FFD,
        PORT_BORDER,
        PORT_XT_PAGE,
        PORT_SYSCONF,
        PORT_MEMCONF,
        PORT_INTMASK
    } port_e;

    // decode to register file
    typedef struct packed {
        logic       wr_stb;
        logic       rd;
        port_e      port;
        logic [1:0] idx;
        data_t      data;
    } port_cmd_t;

    typedef struct packed {
        logic [4:0] spare;
        logic       w0_ram;
        logic [1:0] rom_bank;
    } memconf_t;

    // extended ports, #xxAF with the high byte selecting the register
    localparam data_t XT_PORT_LO = 8'hAF;
    localparam data_t HI_BORDER  = 8'h0F;
    localparam data_t HI_XT_PAGE = 8'h10;
    localparam data_t HI_SYSCONF = 8'h20;
    localparam data_t HI_MEMCONF = 8'h21;
    localparam data_t HI_INTMASK = 8'h2A;

    // classic spectrum ports
    localparam logic [15:0] PORT_7FFD_ADDR = 16'h7FFD;
    localparam data_t       FE_LO          = 8'hFE;

    // #FE border writes land in the upper palette half
    localparam data_t BORDER_FE_BASE = 8'hF0;

    // im2 vector of the frame interrupt
    localparam data_t IM2_VECT_FRM = 8'hFF;

    localparam data_t INTMASK_RST     = 8'h01;
    localparam int    INTMASK_FRM_BIT = 0;

    // unmapped readback
    localparam data_t RD_DEFAULT = 8'hFF;

endpackage

/* tb/zbus_io_tasks.svh */
// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic zx_pkg::data_t rand_bits(input int n);
    zx_pkg::data_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_q = lfsr_next(lfsr_q);
        r = {r[6:0], lfsr_q[0]};
    end
    return r;
endfunction

task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    fail_cnt++;
endtask

task automatic compare_data(input string name, input zx_pkg::data_t exp,
                            input zx_pkg::data_t act);
    if (act !== exp) begin
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        fail_cnt++;
    end else begin
        pass_cnt++;
    end
endtask

task automatic compare_page(input string name, input zx_pkg::page_t exp,
                            input zx_pkg::page_t act);
    if (act !== exp) begin
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        fail_cnt++;
    end else begin
        pass_cnt++;
    end
endtask

task automatic compare_turbo(input string name, input logic [1:0] exp,
                             input logic [1:0] act);
    if (act !== exp) begin
        $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        fail_cnt++;
    end else begin
        pass_cnt++;
    end
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        fail_cnt++;
    end else begin
        pass_cnt++;
    end
endtask

task automatic end_test(input string name, input int fails_before);
    $display("test %s finished with %0d errors", name, fail_cnt - fails_before);
endtask

task automatic wait_dout_en_low();
    int n;
    n = 0;
    while (dout_en !== 1'b0 && n < STB_CYCLES) begin
        @(negedge fclk);
        n++;
    end
    if (dout_en !== 1'b0) begin
        report_error("dout_en stayed high after the bus cycle ended");
    end
endtask

// n counts negedges up to and including the one where int_n matches
task automatic wait_int_n(input logic level, input int limit, output int n, output logic ok);
    n  = 0;
    ok = 1'b0;
    while (!ok && n < limit) begin
        @(negedge fclk);
        n++;
        ok = (int_n === level);
    end
endtask

task automatic io_write(input logic [15:0] addr, input zx_pkg::data_t data);
    logic bad;
    bad = 1'b0;
    @(posedge fclk);
    a      <= addr;
    din    <= data;
    iorq_n <= 1'b0;
    wr_n   <= 1'b0;
    repeat (STB_CYCLES) begin
        @(negedge fclk);
        bad = bad | (dout_en !== 1'b0);
    end
    if (bad) begin
        report_error($sformatf("dout_en went high during the write to %h", addr));
    end
    @(posedge fclk);
    iorq_n <= 1'b1;
    wr_n   <= 1'b1;
    // let the synchronizer drain before a moves again
    repeat (4) @(posedge fclk);
endtask

task automatic io_read(input logic [15:0] addr, output zx_pkg::data_t data);
    logic seen;
    seen = 1'b0;
    data = '0;
    @(posedge fclk);
    a      <= addr;
    iorq_n <= 1'b0;
    rd_n   <= 1'b0;
    repeat (STB_CYCLES) begin
        @(negedge fclk);
        if (!seen && dout_en === 1'b1) begin
            data = dout;
            seen = 1'b1;
        end
    end
    if (!seen) begin
        report_error($sformatf("dout_en never rose during the read of %h", addr));
    end
    @(posedge fclk);
    iorq_n <= 1'b1;
    rd_n   <= 1'b1;
    wait_dout_en_low();
endtask

task automatic int_ack(output zx_pkg::data_t vect, output logic seen);
    seen = 1'b0;
    vect = '0;
    @(posedge fclk);
    m1_n   <= 1'b0;
    iorq_n <= 1'b0;
    repeat (STB_CYCLES) begin
        @(negedge fclk);
        if (!seen && dout_en === 1'b1) begin
            vect = dout;
            seen = 1'b1;
        end
    end
    @(posedge fclk);
    m1_n   <= 1'b1;
    iorq_n <= 1'b1;
    wait_dout_en_low();
endtask

task automatic pulse_int_start();
    @(posedge fclk);
    int_start <= 1'b1;
    @(posedge fclk);
    int_start <= 1'b0;
endtask

task automatic check_window(input logic [1:0] w, input zx_pkg::page_t exp_pg,
                            input logic exp_rom);
    @(posedge fclk);
    a <= {w, 14'h0123};
    @(negedge fclk);
    compare_page($sformatf("mem_page (window %0d)", w), exp_pg, mem_page);
    compare_bit($sformatf("rom_sel (window %0d)", w), exp_rom, rom_sel);
endtask

task automatic test_reset_state();
    int f0;
    f0 = fail_cnt;
    @(negedge fclk);
    compare_bit("int_n", 1'b1, int_n);
    compare_bit("dout_en", 1'b0, dout_en);
    compare_data("border", 8'h00, border);
    compare_bit("beep", 1'b0, beep);
    compare_turbo("turbo", 2'b00, turbo);
    compare_bit("rom_sel", 1'b1, rom_sel);
    compare_page("mem_page", 8'h00, mem_page);
    end_test("reset_state", f0);
endtask

task automatic test_fe_writes();
    int f0;
    zx_pkg::data_t d;
    zx_pkg::data_t hi;
    f0 = fail_cnt;
    repeat (6) begin
        d  = rand_bits(8);
        hi = rand_bits(8);
        io_write({hi, zx_pkg::FE_LO}, d);
        @(negedge fclk);
        compare_data("border", zx_pkg::BORDER_FE_BASE + {5'd0, d[2:0]}, border);
        compare_bit("beep", d[4], beep);
    end
    end_test("fe_writes", f0);
endtask

task automatic test_xt_pages();
    int f0;
    zx_pkg::data_t hi;
    zx_pkg::data_t rb;
    zx_pkg::data_t d;
    f0 = fail_cnt;
    for (int i = 0; i < 4; i++) begin
        exp_page[i] = rand_bits(8);
        hi = zx_pkg::HI_XT_PAGE + 8'(i);
        io_write({hi, zx_pkg::XT_PORT_LO}, exp_page[i]);
    end
    rb = rand_bits(2);
    // w0_ram set, all windows come from ram
    io_write({zx_pkg::HI_MEMCONF, zx_pkg::XT_PORT_LO}, {5'd0, 1'b1, rb[1:0]});
    for (int w = 0; w < 4; w++) begin
        check_window(2'(w), exp_page[w], 1'b0);
    end
    io_write({zx_pkg::HI_MEMCONF, zx_pkg::XT_PORT_LO}, {5'd0, 1'b0, rb[1:0]});
    check_window(2'd0, {6'd0, rb[1:0]}, 1'b1);
    d = rand_bits(8);
    io_write(zx_pkg::PORT_7FFD_ADDR, d);
    exp_page[3] = {5'd0, d[2:0]};
    check_window(2'd3, exp_page[3], 1'b0);
    check_window(2'd0, {6'd0, rb[1], d[4]}, 1'b1);
    end_test("xt_pages", f0);
endtask

task automatic test_readback();
    int f0;
    zx_pkg::data_t k;
    zx_pkg::data_t hi;
    zx_pkg::data_t v;
    f0 = fail_cnt;
    k  = rand_bits(5);
    hi = rand_bits(8);
    @(posedge fclk);
    keys <= k[4:0];
    io_read({hi, zx_pkg::FE_LO}, v);
    compare_data("dout (#FE read)", {3'b111, k[4:0]}, v);
    hi = zx_pkg::HI_XT_PAGE + 8'd2;
    io_read({hi, zx_pkg::XT_PORT_LO}, v);
    compare_data("dout (#12AF read)", exp_page[2], v);
    @(negedge fclk);
    compare_bit("dout_en after reads", 1'b0, dout_en);
    end_test("readback", f0);
endtask

task automatic test_sysconf();
    int f0;
    zx_pkg::data_t d;
    zx_pkg::data_t v;
    f0 = fail_cnt;
    d = rand_bits(8);
    io_write({zx_pkg::HI_BORDER, zx_pkg::XT_PORT_LO}, d);
    @(negedge fclk);
    compare_data("border (#0FAF write)", d, border);
    // a byte and its complement, so both turbo bits toggle
    d = rand_bits(8);
    repeat (2) begin
        io_write({zx_pkg::HI_SYSCONF, zx_pkg::XT_PORT_LO}, d);
        @(negedge fclk);
        compare_turbo("turbo", d[1:0], turbo);
        d = ~d;
    end
    // sysconf is write only
    io_read({zx_pkg::HI_SYSCONF, zx_pkg::XT_PORT_LO}, v);
    compare_data("dout (#20AF read)", 8'hFF, v);
    end_test("sysconf", f0);
endtask

task automatic test_frame_int();
    int f0;
    int n;
    logic ok;
    logic seen;
    zx_pkg::data_t v;
    f0 = fail_cnt;
    // intmask frame bit is set out of reset
    pulse_int_start();
    wait_int_n(1'b0, 4, n, ok);
    if (!ok) begin
        report_error("int_n did not fall after int_start");
    end
    wait_int_n(1'b1, INT_LEN + 2, n, ok);
    if (!ok) begin
        report_error("int_n stayed low longer than INT_LEN plus 2 cycles");
    end else if (n != INT_LEN) begin
        report_error($sformatf("int_n was low for %0d cycles, not %0d", n, INT_LEN));
    end

    pulse_int_start();
    wait_int_n(1'b0, 4, n, ok);
    if (!ok) begin
        report_error("int_n did not fall after the second int_start");
    end
    int_ack(v, seen);
    if (!seen) begin
        report_error("dout_en did not rise during the interrupt acknowledge");
    end else begin
        compare_data("dout (im2 vector)", zx_pkg::IM2_VECT_FRM, v);
    end
    compare_bit("int_n after acknowledge", 1'b1, int_n);

    io_write({zx_pkg::HI_INTMASK, zx_pkg::XT_PORT_LO}, 8'h00);
    pulse_int_start();
    wait_int_n(1'b0, INT_LEN + 2, n, ok);
    if (ok) begin
        report_error("int_n fell although the frame interrupt is masked");
    end
    compare_bit("int_n (masked)", 1'b1, int_n);
    end_test("frame_int", f0);
endtask

/* tb/zbus_io_tb.sv */
`timescale 1ns/1ps

module zbus_io_tb;

    localparam int INT_LEN        = 16;
    localparam int STB_CYCLES     = 8;
    localparam int TIMEOUT_CYCLES = 3000;

    logic          fclk;
    logic          rst_n;
    logic [15:0]   a;
    zx_pkg::data_t din;
    logic          iorq_n;
    logic          rd_n;
    logic          wr_n;
    logic          m1_n;
    logic [4:0]    keys;
    logic          int_start;
    zx_pkg::data_t dout;
    logic          dout_en;
    logic          int_n;
    zx_pkg::data_t border;
    logic          beep;
    logic [1:0]    turbo;
    zx_pkg::page_t mem_page;
    logic          rom_sel;

    int            pass_cnt;
    int            fail_cnt;
    int            cycle_cnt;
    logic [15:0]   lfsr_q;
    // pages written to the four windows, kept for readback
    zx_pkg::page_t exp_page [4];

    zbus_io #(
        .INT_LEN (INT_LEN)
    ) zbus_io_i (
        .fclk      (fclk),
        .rst_n     (rst_n),
        .a         (a),
        .din       (din),
        .iorq_n    (iorq_n),
        .rd_n      (rd_n),
        .wr_n      (wr_n),
        .m1_n      (m1_n),
        .keys      (keys),
        .int_start (int_start),
        .dout      (dout),
        .dout_en   (dout_en),
        .int_n     (int_n),
        .border    (border),
        .beep      (beep),
        .turbo     (turbo),
        .mem_page  (mem_page),
        .rom_sel   (rom_sel)
    );

    `include "zbus_io_tasks.svh"

    initial begin
        fclk = 1'b0;
        forever #20 fclk = ~fclk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge fclk);
            cycle_cnt++;
        end
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        a         = '0;
        din       = '0;
        iorq_n    = 1'b1;
        rd_n      = 1'b1;
        wr_n      = 1'b1;
        m1_n      = 1'b1;
        keys      = '0;
        int_start = 1'b0;
        lfsr_q    = 16'd50819;
        pass_cnt  = 0;
        fail_cnt  = 0;
        repeat (5) @(posedge fclk);
        rst_n <= 1'b1;
        @(posedge fclk);

        test_reset_state();
        test_fe_writes();
        test_xt_pages();
        test_readback();
        test_sysconf();
        test_frame_int();

        $display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* zbus_io.f */
+incdir+tb
design/zx_pkg.sv
design/zbus_decode.sv
design/zport_regs.sv
design/zint_gen.sv
design/zbus_io.sv
tb/zbus_io_tb.sv
